//--- logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Fetch address out of reset
`define PC_RESET 32'h1c00_0000

// Fixed exception entry
`define EENTRY 32'h1c00_8000

// Direct-mapped BTB geometry
`define BTB_ENTRIES 16
`define BTB_IDX_W 4     // PC[5:2]
`define BTB_TAG_W 8     // PC[13:6]

// Countdown timer, initial count sits in TCFG[17:2]
`define TIMER_W 16

`endif

//--- logic/excp_pkg.sv
`default_nettype none

package excp_pkg;

    // Exception codes as written to ESTAT.ecode
    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d
    } ecode_t;

    // Control register addresses
    typedef enum logic [3:0] {
        CSR_CRMD  = 4'h0,   // ie in bit 2
        CSR_ERA   = 4'h1,
        CSR_ESTAT = 4'h2,
        CSR_TCFG  = 4'h3,
        CSR_TICLR = 4'h4    // Write only
    } csr_addr_t;

endpackage

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package fetch_pkg;

    // Winner of the next-PC choice
    typedef enum logic [1:0] {
        SRC_SEQ    = 2'd0,
        SRC_BTB    = 2'd1,
        SRC_BRMISS = 2'd2,
        SRC_EXCP   = 2'd3
    } redirect_src_t;

    // BTB addressing slices of the PC
    typedef logic [`BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [`BTB_TAG_W-1:0] btb_tag_t;

endpackage

`default_nettype wire

//--- logic/bpu.sv
`default_nettype none

`include "cpu_params.svh"

module bpu
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] fetch_pc,
    output logic        pred_taken,
    output logic [31:0] pred_target,
    input  logic        br_valid,
    input  logic [31:0] br_pc,
    input  logic        br_taken,
    input  logic [31:0] br_target
);

    logic [`BTB_ENTRIES-1:0] valid;
    btb_tag_t                tags    [`BTB_ENTRIES];
    logic [31:0]             targets [`BTB_ENTRIES];

    btb_idx_t fetch_idx;
    btb_tag_t fetch_tag;
    btb_idx_t br_idx;
    btb_tag_t br_tag;

    assign fetch_idx = fetch_pc[`BTB_IDX_W+1:2];
    assign fetch_tag = fetch_pc[`BTB_TAG_W+`BTB_IDX_W+1:`BTB_IDX_W+2];
    assign br_idx    = br_pc[`BTB_IDX_W+1:2];
    assign br_tag    = br_pc[`BTB_TAG_W+`BTB_IDX_W+1:`BTB_IDX_W+2];

    // Lookup is purely combinational on the current fetch PC
    assign pred_taken  = valid[fetch_idx] && (tags[fetch_idx] == fetch_tag);
    assign pred_target = targets[fetch_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (br_valid) begin
            if (br_taken) begin
                valid[br_idx] <= 1'b1;
            end else if (tags[br_idx] == br_tag) begin
                // Only drop the entry if it belongs to this branch
                valid[br_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br_valid && br_taken) begin
            tags[br_idx]    <= br_tag;
            targets[br_idx] <= br_target;
        end
    end

endmodule

`default_nettype wire

//--- logic/exception_unit.sv
`default_nettype none

`include "cpu_params.svh"

module exception_unit
    import excp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_valid,
    input  logic [31:0] ex_pc,
    input  ecode_t      ex_ecode,
    input  logic        ex_ertn,
    input  logic        csr_we,
    input  csr_addr_t   csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    output logic        excp_flush,
    output logic [31:0] excp_target
);

    logic                crmd_ie;
    logic [31:0]         era;
    ecode_t              estat_ecode;
    logic                ti_pending;
    logic                tcfg_en;
    logic [`TIMER_W-1:0] tcfg_init;
    logic                timer_run;
    logic [`TIMER_W-1:0] timer_cnt;

    logic take_int;
    logic excp_take;
    logic ertn_take;

    // Interrupt rides on whatever instruction sits in the memory stage
    assign take_int  = ti_pending && crmd_ie && ex_valid;
    assign excp_take = take_int || (ex_valid && !ex_ertn);
    assign ertn_take = ex_ertn && !excp_take;

    assign excp_flush  = excp_take || ertn_take;
    assign excp_target = excp_take ? `EENTRY : era;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_ie     <= 1'b0;
            estat_ecode <= ECODE_INT;
        end else if (excp_take) begin
            crmd_ie     <= 1'b0;
            estat_ecode <= take_int ? ECODE_INT : ex_ecode;
        end else if (ertn_take) begin
            crmd_ie <= 1'b1;
        end else if (csr_we && csr_addr == CSR_CRMD) begin
            crmd_ie <= csr_wdata[2];
        end
    end

    always_ff @(posedge clk) begin
        if (excp_take)
            era <= ex_pc;
        else if (csr_we && csr_addr == CSR_ERA)
            era <= csr_wdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tcfg_en    <= 1'b0;
            tcfg_init  <= '0;
            timer_run  <= 1'b0;
            timer_cnt  <= '0;
            ti_pending <= 1'b0;
        end else begin
            if (csr_we && csr_addr == CSR_TCFG) begin
                tcfg_en   <= csr_wdata[0];
                tcfg_init <= csr_wdata[`TIMER_W+1:2];
                timer_run <= csr_wdata[0];   // Restart on every write
                timer_cnt <= csr_wdata[`TIMER_W+1:2];
            end else if (timer_run) begin
                if (timer_cnt == '0) begin
                    timer_run  <= 1'b0;      // One shot
                    ti_pending <= 1'b1;
                end else begin
                    timer_cnt <= timer_cnt - `TIMER_W'(1);
                end
            end
            if (csr_we && csr_addr == CSR_TICLR && csr_wdata[0])
                ti_pending <= 1'b0;
        end
    end

    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            CSR_CRMD:  csr_rdata[2] = crmd_ie;
            CSR_ERA:   csr_rdata = era;
            CSR_ESTAT: begin
                csr_rdata[21:16] = estat_ecode;
                csr_rdata[11]    = ti_pending;
            end
            CSR_TCFG: begin
                csr_rdata[0]            = tcfg_en;
                csr_rdata[`TIMER_W+1:2] = tcfg_init;
            end
            default: csr_rdata = '0;   // TICLR reads zero
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pc_redirect.sv
`default_nettype none

`include "cpu_params.svh"

module pc_redirect
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        pred_taken,
    input  logic [31:0] pred_target,
    input  logic        br_miss,
    input  logic [31:0] br_target,
    input  logic        excp_flush,
    input  logic [31:0] excp_target,
    output logic [31:0] fetch_pc,
    output logic        flush_if1,
    output logic        flush_if2,
    output logic        flush_id,
    output logic        flush_ex,
    output logic        flush_mem1
);

    redirect_src_t src;
    logic [31:0]   pc_q;
    logic [31:0]   pc_next;
    logic          backend_redirect;
    logic          hold;

    assign backend_redirect = excp_flush || br_miss;

    // Back-end redirects override the stall
    assign hold = stall && !backend_redirect;

    always_comb begin
        if (excp_flush)
            src = SRC_EXCP;
        else if (br_miss)
            src = SRC_BRMISS;
        else if (pred_taken)
            src = SRC_BTB;
        else
            src = SRC_SEQ;
    end

    always_comb begin
        case (src)
            SRC_EXCP:   pc_next = excp_target;
            SRC_BRMISS: pc_next = br_target;
            SRC_BTB:    pc_next = pred_target;
            default:    pc_next = pc_q + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc_q <= `PC_RESET;
        else if (!hold)
            pc_q <= pc_next;
    end

    assign fetch_pc = pc_q;

    // Front stages die on any back-end redirect, mem1 only on exceptions
    assign flush_if1  = backend_redirect;
    assign flush_if2  = backend_redirect;
    assign flush_id   = backend_redirect;
    assign flush_ex   = backend_redirect;
    assign flush_mem1 = excp_flush;

endmodule

`default_nettype wire

//--- logic/redirect_top.sv
`default_nettype none

module redirect_top
    import excp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        br_valid,
    input  logic [31:0] br_pc,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    input  logic        br_miss,
    input  logic        ex_valid,
    input  logic [31:0] ex_pc,
    input  ecode_t      ex_ecode,
    input  logic        ex_ertn,
    input  logic        csr_we,
    input  csr_addr_t   csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] fetch_pc,
    output logic [31:0] csr_rdata,
    output logic        flush_if1,
    output logic        flush_if2,
    output logic        flush_id,
    output logic        flush_ex,
    output logic        flush_mem1
);

    logic        pred_taken;
    logic [31:0] pred_target;
    logic        excp_flush;
    logic [31:0] excp_target;

    bpu i_bpu (
        .clk,
        .rst_n,
        .fetch_pc,
        .pred_taken,
        .pred_target,
        .br_valid,
        .br_pc,
        .br_taken,
        .br_target
    );

    exception_unit i_excp (
        .clk,
        .rst_n,
        .ex_valid,
        .ex_pc,
        .ex_ecode,
        .ex_ertn,
        .csr_we,
        .csr_addr,
        .csr_wdata,
        .csr_rdata,
        .excp_flush,
        .excp_target
    );

    // br_target doubles as the corrected PC on a miss
    pc_redirect i_pc (
        .clk,
        .rst_n,
        .stall,
        .pred_taken,
        .pred_target,
        .br_miss,
        .br_target,
        .excp_flush,
        .excp_target,
        .fetch_pc,
        .flush_if1,
        .flush_if2,
        .flush_id,
        .flush_ex,
        .flush_mem1
    );

endmodule

`default_nettype wire

//--- sim/redirect_assertions.sv
`default_nettype none

`include "cpu_params.svh"

module redirect_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic        excp_flush,
    input logic        flush_ex,
    input logic        flush_mem1,
    input logic [31:0] fetch_pc,
    input logic [31:0] era
);

    int unsigned fails = 0;

    // mem1 never flushes on its own
    assert property (@(posedge clk) disable iff (!rst_n) flush_mem1 |-> flush_ex)
        else begin
            fails++;
            $error("flush_mem1 high without flush_ex");
        end

    assert property (@(posedge clk) disable iff (!rst_n) stall && !flush_ex |=> $stable(fetch_pc))
        else begin
            fails++;
            $error("fetch_pc moved under stall with no flush");
        end

    // Exception goes to the entry, ertn to the old ERA
    assert property (@(posedge clk) disable iff (!rst_n)
        excp_flush |=> (fetch_pc == `EENTRY) || (fetch_pc == $past(era)))
        else begin
            fails++;
            $error("fetch_pc after excp_flush is neither EENTRY nor ERA");
        end

endmodule

bind redirect_top redirect_assertions i_assert (
    .clk, .rst_n, .stall, .excp_flush, .flush_ex, .flush_mem1, .fetch_pc, .era(i_excp.era)
);

`default_nettype wire

//--- sim/redirect_tb.sv
`default_nettype none

`include "cpu_params.svh"

module redirect_tb
    import excp_pkg::*;
;

    typedef struct packed {
        logic [6:0]  ctl;      // stall br_valid br_taken br_miss ex_valid ex_ertn csr_we
        logic [31:0] pc;       // Drives br_pc and ex_pc
        logic [31:0] val;      // Drives br_target and csr_wdata
        ecode_t      ecode;
        csr_addr_t   addr;
        logic [31:0] exp_pc;
        logic [1:0]  exp_fl;   // flush_ex, flush_mem1
        logic [31:0] exp_csr;
        logic        skip;
    } row_t;

    logic        clk, rst_n, stall, br_valid, br_taken, br_miss, ex_valid, ex_ertn, csr_we;
    logic [31:0] br_pc, br_target, ex_pc, csr_wdata, fetch_pc, csr_rdata;
    ecode_t      ex_ecode;
    csr_addr_t   csr_addr;
    logic        flush_if1, flush_if2, flush_id, flush_ex, flush_mem1;

    row_t        rows[$];
    string       names[$];
    logic [31:0] lfsr, w, b, x, t, e, en;
    int unsigned pc_errs = 0, flush_errs = 0, csr_errs = 0, asrt_fails = 0;
    int          limit = 0, cycles = 0;

    redirect_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            pc_errs++;
            $display("** Error %s: fetch_pc expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flush(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flush_errs++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_csr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            csr_errs++;
            $display("** Error %s: csr_rdata expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic add_row(input string name, input logic [6:0] ctl, input logic [31:0] pc,
                           input logic [31:0] val, input ecode_t ecode, input csr_addr_t addr,
                           input logic [31:0] exp_pc, input logic [1:0] exp_fl,
                           input logic [31:0] exp_csr, input logic skip);
        row_t r;
        r = '{ctl, pc, val, ecode, addr, exp_pc, exp_fl, exp_csr, skip};
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        {stall, br_valid, br_taken, br_miss, ex_valid, ex_ertn, csr_we} = r.ctl;
        br_pc     = r.pc;
        ex_pc     = r.pc;
        br_target = r.val;
        csr_wdata = r.val;
        ex_ecode  = r.ecode;
        csr_addr  = r.addr;
    endtask

    task automatic check_row(input string name, input row_t r);
        check_pc(name, r.exp_pc, fetch_pc);
        check_flush({name, " flush_if1"}, r.exp_fl[1], flush_if1);
        check_flush({name, " flush_if2"}, r.exp_fl[1], flush_if2);
        check_flush({name, " flush_id"}, r.exp_fl[1], flush_id);
        check_flush({name, " flush_ex"}, r.exp_fl[1], flush_ex);
        check_flush({name, " flush_mem1"}, r.exp_fl[0], flush_mem1);
        if (!r.skip)
            check_csr(name, r.exp_csr, csr_rdata);
    endtask

    initial begin
        rst_n = 1'b0;
        apply_row('0);
        lfsr = 32'h951b_ecfb;
        w = rand_bits(22);
        t = {4'h3, w[21:0], 6'h00};   // BTB index 0
        w = rand_bits(26);
        e = {4'h2, w[25:0], 2'b00};
        b = `PC_RESET;
        x = b + 8;
        en = `EENTRY;

        add_row("seq", 7'b0000000, '0, '0, ECODE_SYS, CSR_CRMD, b + 4, 2'b00, '0, 1'b0);
        add_row("stall", 7'b1000000, '0, '0, ECODE_SYS, CSR_CRMD, b + 4, 2'b00, '0, 1'b0);
        add_row("br_taken", 7'b0110000, x, t, ECODE_SYS, CSR_CRMD, b + 8, 2'b00, '0, 1'b0);
        add_row("btb_hit", 7'b0000000, '0, '0, ECODE_SYS, CSR_CRMD, t, 2'b00, '0, 1'b0);
        add_row("seq_t", 7'b0000000, '0, '0, ECODE_SYS, CSR_CRMD, t + 4, 2'b00, '0, 1'b0);
        add_row("br_not_taken", 7'b0100000, x, '0, ECODE_SYS, CSR_CRMD, t + 8, 2'b00, '0, 1'b0);
        add_row("miss_stall", 7'b1001000, '0, x, ECODE_SYS, CSR_CRMD, x, 2'b10, '0, 1'b0);
        add_row("nt_fallback", 7'b0000000, '0, '0, ECODE_SYS, CSR_CRMD, x + 4, 2'b00, '0, 1'b0);
        add_row("crmd_set", 7'b0000001, '0, 4, ECODE_SYS, CSR_CRMD, x + 8, 2'b00, 4, 1'b0);
        add_row("excp_sys", 7'b0000100, e, '0, ECODE_SYS, CSR_ERA, en, 2'b11, e, 1'b0);
        add_row("estat_sys", 7'b0000000, '0, '0, ECODE_SYS, CSR_ESTAT, en + 4, 2'b00,
                32'h000b_0000, 1'b0);
        add_row("ie_cleared", 7'b0000000, '0, '0, ECODE_SYS, CSR_CRMD, en + 8, 2'b00, '0, 1'b0);
        add_row("ertn", 7'b0000010, '0, '0, ECODE_SYS, CSR_CRMD, e, 2'b11, 4, 1'b0);
        add_row("tcfg_wr", 7'b0000001, '0, 5, ECODE_SYS, CSR_TCFG, e + 4, 2'b00, 5, 1'b0);
        add_row("tick", 7'b0000000, '0, '0, ECODE_SYS, CSR_ESTAT, e + 8, 2'b00,
                32'h000b_0000, 1'b0);
        add_row("pending", 7'b0000000, '0, '0, ECODE_SYS, CSR_ESTAT, e + 12, 2'b00,
                32'h000b_0800, 1'b0);
        add_row("ie_off", 7'b0000001, '0, '0, ECODE_SYS, CSR_CRMD, e + 16, 2'b00, '0, 1'b0);
        add_row("excp_brk", 7'b0000100, b + 32'h200, '0, ECODE_BRK, CSR_ESTAT, en, 2'b11,
                32'h000c_0800, 1'b0);
        add_row("ertn_2", 7'b0000010, '0, '0, ECODE_SYS, CSR_CRMD, b + 32'h200, 2'b11, 4, 1'b0);
        add_row("int_taken", 7'b0000100, b + 32'h300, '0, ECODE_INE, CSR_ESTAT, en, 2'b11,
                32'h0000_0800, 1'b0);
        add_row("ticlr", 7'b0000001, '0, 1, ECODE_SYS, CSR_TICLR, en + 4, 2'b00, '0, 1'b0);
        add_row("estat_clr", 7'b0000000, '0, '0, ECODE_SYS, CSR_ESTAT, en + 8, 2'b00, '0, 1'b0);
        add_row("hold_upd", 7'b1110000, en + 8, t, ECODE_SYS, CSR_CRMD, en + 8, 2'b00, '0, 1'b1);
        // Exception, branch miss and BTB hit all at once
        add_row("excp_wins", 7'b0001100, b + 32'h500, x, ECODE_ADEF, CSR_ESTAT, en, 2'b11,
                32'h0008_0000, 1'b0);
        add_row("seq_end", 7'b0000000, '0, '0, ECODE_SYS, CSR_CRMD, en + 4, 2'b00, '0, 1'b1);
        limit = rows.size() + 4 + 20;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_pc("reset", `PC_RESET, fetch_pc);
        check_flush("reset flush_ex", 1'b0, flush_ex);
        check_flush("reset flush_mem1", 1'b0, flush_mem1);
        check_csr("reset crmd", '0, csr_rdata);

        foreach (rows[i]) begin
            apply_row(rows[i]);
            @(negedge clk);   // Outputs settled since the rising edge
            check_row(names[i], rows[i]);
        end

        asrt_fails = i_dut.i_assert.fails;
        $display("pc errors %0d, flush errors %0d, csr errors %0d, assertion failures %0d",
                 pc_errs, flush_errs, csr_errs, asrt_fails);
        if (pc_errs + flush_errs + csr_errs + asrt_fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/excp_pkg.sv
logic/fetch_pkg.sv
logic/bpu.sv
logic/exception_unit.sv
logic/pc_redirect.sv
logic/redirect_top.sv
sim/redirect_assertions.sv
sim/redirect_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the redirect testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f list.f --top-module redirect_tb -o redirect_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/redirect_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
    exit 0
fi
exit 1
